//--- event_builder_settings.svh
`ifndef EVENT_BUILDER_SETTINGS_SVH
`define EVENT_BUILDER_SETTINGS_SVH

// serial links feeding the builder
`define EB_NUM_LINKS      4
// per-link payload FIFO, 64-bit words
`define EB_FIFO_DEPTH     64
// longest accepted fragment, 32-bit words
`define EB_MAX_FRAG_WORDS 128

// top byte of every header word
`define EB_TAG_EVENT      8'hE5
// link number is added on top of this one
`define EB_TAG_LINK       8'hA0

`endif

//--- event_pkg.sv
package event_pkg;

    // event header, one per built event
    typedef struct packed {
        logic [7:0]  tag;
        logic [3:0]  link_mask;
        logic [19:0] rsvd;
        logic [31:0] event_num;
    } event_hdr_t;

    // link header, one per enabled link in the event
    typedef struct packed {
        logic [7:0]  tag;
        logic [3:0]  link_num;
        logic [3:0]  rsvd;
        logic [15:0] event_count;
        // length in 32-bit words as received
        logic [15:0] frag_len;
        // length in packed 64-bit words
        logic [15:0] pay_len;
    } link_hdr_t;

    // one header word, read by its tag as either kind
    typedef union packed {
        event_hdr_t ev;
        link_hdr_t  lnk;
    } hdr_word_u;

endpackage

//--- ctrl_pkg.sv
package ctrl_pkg;

    typedef enum logic [3:0] {
        REG_CTRL = 4'd0,
        REG_MASK = 4'd1
    } reg_addr_e;

    // register read-back layout
    typedef struct packed {
        logic [19:0] rsvd_hi;
        logic [3:0]  link_mask;
        logic [6:0]  rsvd_lo;
        logic        event_reset;
    } ctrl_word_t;

endpackage

//--- sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH = 64,
    parameter int DEPTH = 64
) (
    input  logic                   aclk,
    input  logic                   rst_i,
    input  logic                   wr_en_i,
    input  logic [WIDTH-1:0]       wr_data_i,
    output logic                   full_o,
    input  logic                   rd_en_i,
    output logic [WIDTH-1:0]       rd_data_o,
    output logic                   empty_o,
    output logic [$clog2(DEPTH):0] level_o
);
    localparam int AW = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr_q;
    logic [AW-1:0]    rd_ptr_q;
    logic [AW:0]      count_q;

    assign full_o    = count_q == (AW+1)'(DEPTH);
    assign empty_o   = count_q == '0;
    assign level_o   = count_q;
    // first word falls through
    assign rd_data_o = mem[rd_ptr_q];

    always_ff @(posedge aclk) begin
        if (wr_en_i) begin
            mem[wr_ptr_q] <= wr_data_i;
        end
    end

    always_ff @(posedge aclk) begin
        if (rst_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_en_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (rd_en_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({wr_en_i, rd_en_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;
            endcase
        end
    end

    assert property (@(posedge aclk) disable iff (rst_i) wr_en_i |-> !full_o);
    assert property (@(posedge aclk) disable iff (rst_i) rd_en_i |-> !empty_o);

endmodule

//--- event_ctrl_regs.sv
`timescale 1ns/1ps
`include "event_builder_settings.svh"

module event_ctrl_regs (
    input  logic                     aclk,
    input  logic                     rst_i,
    input  logic                     reg_wr_i,
    input  logic [3:0]               reg_addr_i,
    input  logic [31:0]              reg_wdata_i,
    output logic [31:0]              reg_rdata_o,
    output logic                     ev_rst_o,
    output logic [`EB_NUM_LINKS-1:0] link_mask_o
);
    logic                     soft_rst_q;
    logic [`EB_NUM_LINKS-1:0] mask_q;
    logic                     ev_rst_q;
    ctrl_pkg::ctrl_word_t     rd_word;

    // writes land on the next edge
    always_ff @(posedge aclk) begin
        if (rst_i) begin
            soft_rst_q <= 1'b0;
            mask_q     <= '1;
        end else if (reg_wr_i) begin
            case (reg_addr_i)
                ctrl_pkg::REG_CTRL: soft_rst_q <= reg_wdata_i[0];
                ctrl_pkg::REG_MASK: mask_q <= reg_wdata_i[8 +: `EB_NUM_LINKS];
                default: ;
            endcase
        end
    end

    // event reset held as long as the soft bit stays set
    always_ff @(posedge aclk) begin
        if (rst_i) begin
            ev_rst_q <= 1'b1;
        end else begin
            ev_rst_q <= soft_rst_q;
        end
    end

    always_comb begin
        rd_word = '0;
        case (reg_addr_i)
            ctrl_pkg::REG_CTRL: rd_word.event_reset = soft_rst_q;
            ctrl_pkg::REG_MASK: rd_word.link_mask = mask_q;
            default: ;
        endcase
    end

    assign reg_rdata_o = rd_word;
    assign ev_rst_o    = ev_rst_q;
    assign link_mask_o = mask_q;

    // soft reset reaches the datapath two edges after the write
    assert property (@(posedge aclk) disable iff (rst_i)
        reg_wr_i && reg_addr_i == ctrl_pkg::REG_CTRL && reg_wdata_i[0] |-> ##2 ev_rst_o);

endmodule

//--- link_event_accumulator.sv
`timescale 1ns/1ps
`include "event_builder_settings.svh"

module link_event_accumulator (
    input  logic                 aclk,
    input  logic                 rst_i,
    input  logic [3:0]           link_id_i,
    input  logic                 enable_i,
    input  logic [31:0]          s_tdata_i,
    input  logic                 s_tvalid_i,
    input  logic                 s_tlast_i,
    output logic                 s_tready_o,
    output logic [63:0]          payload_o,
    output logic                 payload_valid_o,
    input  logic                 payload_pop_i,
    output event_pkg::hdr_word_u hdr_o,
    output logic                 frag_ready_o,
    input  logic                 hdr_taken_i
);
    localparam int LW = $clog2(`EB_FIFO_DEPTH) + 1;

    logic                 beat;
    logic                 fifo_wr;
    logic [63:0]          fifo_wdata;
    logic                 fifo_full;
    logic                 fifo_empty;
    logic [LW-1:0]        fifo_level;
    logic                 have_low_q;
    logic [31:0]          low_q;
    logic [15:0]          frag_words_q;
    logic [15:0]          pay_words_q;
    logic [15:0]          ev_count_q;
    logic                 frag_ready_q;
    event_pkg::hdr_word_u hdr_q;

    // a masked link swallows its data
    assign s_tready_o = !enable_i || !(fifo_full || frag_ready_q);
    assign beat       = s_tvalid_i && s_tready_o && enable_i;

    // second word of a pair, or a lone last word padded with zeros
    assign fifo_wr    = beat && (have_low_q || s_tlast_i);
    assign fifo_wdata = have_low_q ? {s_tdata_i, low_q} : {32'h0, s_tdata_i};

    sync_fifo #(
        .WIDTH (64),
        .DEPTH (`EB_FIFO_DEPTH)
    ) u_fifo (
        .aclk      (aclk),
        .rst_i     (rst_i),
        .wr_en_i   (fifo_wr),
        .wr_data_i (fifo_wdata),
        .full_o    (fifo_full),
        .rd_en_i   (payload_pop_i),
        .rd_data_o (payload_o),
        .empty_o   (fifo_empty),
        .level_o   (fifo_level)
    );

    assign payload_valid_o = !fifo_empty;
    assign hdr_o           = hdr_q;
    assign frag_ready_o    = frag_ready_q;

    always_ff @(posedge aclk) begin
        if (rst_i) begin
            have_low_q   <= 1'b0;
            frag_words_q <= '0;
            pay_words_q  <= '0;
            ev_count_q   <= '0;
            frag_ready_q <= 1'b0;
        end else begin
            if (hdr_taken_i) begin
                frag_ready_q <= 1'b0;
            end
            if (beat) begin
                have_low_q <= !have_low_q && !s_tlast_i;
                if (s_tlast_i) begin
                    frag_words_q <= '0;
                    pay_words_q  <= '0;
                    ev_count_q   <= ev_count_q + 16'd1;
                    frag_ready_q <= 1'b1;
                end else begin
                    frag_words_q <= frag_words_q + 16'd1;
                    if (fifo_wr) begin
                        pay_words_q <= pay_words_q + 16'd1;
                    end
                end
            end
        end
    end

    ////////////////////
    // low half and link header
    ////////////////////
    always_ff @(posedge aclk) begin
        if (beat && !have_low_q) begin
            low_q <= s_tdata_i;
        end
        if (beat && s_tlast_i) begin
            hdr_q.lnk.tag         <= `EB_TAG_LINK + {4'h0, link_id_i};
            hdr_q.lnk.link_num    <= link_id_i;
            hdr_q.lnk.rsvd        <= '0;
            hdr_q.lnk.event_count <= ev_count_q;
            // the last beat always writes one more payload word
            hdr_q.lnk.frag_len    <= frag_words_q + 16'd1;
            hdr_q.lnk.pay_len     <= pay_words_q + 16'd1;
        end
    end

    assert property (@(posedge aclk) disable iff (rst_i)
        beat |-> frag_words_q < 16'(`EB_MAX_FRAG_WORDS));
    // the whole fragment sits in the FIFO once its header is posted
    assert property (@(posedge aclk) disable iff (rst_i)
        $rose(frag_ready_q) |-> 16'(fifo_level) == hdr_q.lnk.pay_len);

endmodule

//--- event_header_merger.sv
`timescale 1ns/1ps
`include "event_builder_settings.svh"

module event_header_merger (
    input  logic                     aclk,
    input  logic                     rst_i,
    input  logic [`EB_NUM_LINKS-1:0] link_mask_i,
    input  logic [`EB_NUM_LINKS-1:0] frag_ready_i,
    output logic [`EB_NUM_LINKS-1:0] hdr_taken_o,
    output logic                     start_o,
    output event_pkg::hdr_word_u     event_hdr_o,
    output logic [`EB_NUM_LINKS-1:0] event_mask_o,
    input  logic                     done_i
);
    logic                     all_ready;
    logic                     launch;
    logic                     busy_q;
    logic                     start_q;
    logic [`EB_NUM_LINKS-1:0] mask_q;
    logic [31:0]              evnum_q;
    event_pkg::hdr_word_u     hdr_q;

    assign all_ready = (link_mask_i != '0) && ((frag_ready_i & link_mask_i) == link_mask_i);
    assign launch    = !busy_q && all_ready;

    // release headers in the done cycle so the ready levels drop together with busy
    assign hdr_taken_o  = done_i ? mask_q : '0;
    assign start_o      = start_q;
    assign event_hdr_o  = hdr_q;
    assign event_mask_o = mask_q;

    always_ff @(posedge aclk) begin
        if (rst_i) begin
            busy_q  <= 1'b0;
            start_q <= 1'b0;
            mask_q  <= '0;
            evnum_q <= '0;
        end else begin
            start_q <= 1'b0;
            if (done_i) begin
                busy_q <= 1'b0;
            end else if (launch) begin
                busy_q  <= 1'b1;
                start_q <= 1'b1;
                mask_q  <= link_mask_i;
                evnum_q <= evnum_q + 32'd1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (launch) begin
            hdr_q.ev.tag       <= `EB_TAG_EVENT;
            hdr_q.ev.link_mask <= link_mask_i;
            hdr_q.ev.rsvd      <= '0;
            hdr_q.ev.event_num <= evnum_q;
        end
    end

    // readout only finishes an event that was started
    assert property (@(posedge aclk) disable iff (rst_i) done_i |-> busy_q);

endmodule

//--- event_readout.sv
`timescale 1ns/1ps
`include "event_builder_settings.svh"

module event_readout (
    input  logic                                           aclk,
    input  logic                                           rst_i,
    input  logic                                           start_i,
    input  event_pkg::hdr_word_u                           event_hdr_i,
    input  logic [`EB_NUM_LINKS-1:0]                       event_mask_i,
    input  event_pkg::hdr_word_u [`EB_NUM_LINKS-1:0]       link_hdr_i,
    input  logic [`EB_NUM_LINKS-1:0][63:0]                 payload_i,
    input  logic [`EB_NUM_LINKS-1:0]                       payload_valid_i,
    output logic [`EB_NUM_LINKS-1:0]                       payload_pop_o,
    output logic                                           done_o,
    output logic [63:0]                                    m_tdata_o,
    output logic                                           m_tvalid_o,
    output logic                                           m_tlast_o,
    input  logic                                           m_tready_i
);
    localparam int N  = `EB_NUM_LINKS;
    localparam int IW = $clog2(N);

    typedef enum logic [1:0] {S_IDLE, S_LHDR, S_PAY, S_DRAIN} state_e;

    state_e        state_q;
    logic [N-1:0]  rem_q;
    logic [15:0]   remain_q;
    logic [IW-1:0] cur;
    logic [N-1:0]  cur_bit;
    logic          last_link;
    logic          can_load;
    logic          pay_take;
    logic [63:0]   m_tdata_q;
    logic          m_tvalid_q;
    logic          m_tlast_q;
    logic          done_q;

    function automatic logic [IW-1:0] first_set(input logic [N-1:0] m);
        logic [IW-1:0] idx;
        idx = '0;
        for (int i = N - 1; i >= 0; i--) begin
            if (m[i]) begin
                idx = IW'(i);
            end
        end
        return idx;
    endfunction

    // lowest link still to send
    assign cur       = first_set(rem_q);
    assign cur_bit   = N'(1) << cur;
    assign last_link = (rem_q & ~cur_bit) == '0;
    // output register is free after this edge
    assign can_load  = !m_tvalid_q || m_tready_i;
    assign pay_take  = (state_q == S_PAY) && can_load && payload_valid_i[cur];

    assign payload_pop_o = pay_take ? cur_bit : '0;
    assign m_tdata_o     = m_tdata_q;
    assign m_tvalid_o    = m_tvalid_q;
    assign m_tlast_o     = m_tlast_q;
    assign done_o        = done_q;

    always_ff @(posedge aclk) begin
        if (rst_i) begin
            state_q    <= S_IDLE;
            rem_q      <= '0;
            m_tvalid_q <= 1'b0;
            m_tlast_q  <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (m_tvalid_q && m_tready_i) begin
                m_tvalid_q <= 1'b0;
            end
            case (state_q)
                S_IDLE: if (start_i) begin
                    rem_q      <= event_mask_i;
                    m_tvalid_q <= 1'b1;
                    m_tlast_q  <= 1'b0;
                    state_q    <= S_LHDR;
                end
                S_LHDR: if (can_load) begin
                    m_tvalid_q <= 1'b1;
                    state_q    <= S_PAY;
                end
                S_PAY: if (pay_take) begin
                    m_tvalid_q <= 1'b1;
                    if (remain_q == 16'd1) begin
                        if (last_link) begin
                            m_tlast_q <= 1'b1;
                            state_q   <= S_DRAIN;
                        end else begin
                            rem_q   <= rem_q & ~cur_bit;
                            state_q <= S_LHDR;
                        end
                    end
                end
                // hold the final word until it is taken
                S_DRAIN: if (m_tready_i) begin
                    m_tlast_q <= 1'b0;
                    done_q    <= 1'b1;
                    state_q   <= S_IDLE;
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        case (state_q)
            S_IDLE: if (start_i) begin
                m_tdata_q <= event_hdr_i;
            end
            S_LHDR: if (can_load) begin
                m_tdata_q <= link_hdr_i[cur];
                remain_q  <= link_hdr_i[cur].lnk.pay_len;
            end
            S_PAY: if (pay_take) begin
                m_tdata_q <= payload_i[cur];
                remain_q  <= remain_q - 16'd1;
            end
            default: ;
        endcase
    end

    // the whole fragment is already in its FIFO, so a payload word is always waiting
    assert property (@(posedge aclk) disable iff (rst_i)
        state_q == S_PAY |-> payload_valid_i[cur]);
    // merger must not launch while an event is still going out
    assert property (@(posedge aclk) disable iff (rst_i) start_i |-> state_q == S_IDLE);

endmodule

//--- event_builder_top.sv
`timescale 1ns/1ps
`include "event_builder_settings.svh"

module event_builder_top (
    input  logic                           aclk,
    input  logic                           rst_i,
    input  logic                           reg_wr_i,
    input  logic [3:0]                     reg_addr_i,
    input  logic [31:0]                    reg_wdata_i,
    output logic [31:0]                    reg_rdata_o,
    input  logic [`EB_NUM_LINKS-1:0][31:0] s_link_tdata_i,
    input  logic [`EB_NUM_LINKS-1:0]       s_link_tvalid_i,
    input  logic [`EB_NUM_LINKS-1:0]       s_link_tlast_i,
    output logic [`EB_NUM_LINKS-1:0]       s_link_tready_o,
    output logic [63:0]                    m_ev_tdata_o,
    output logic                           m_ev_tvalid_o,
    output logic                           m_ev_tlast_o,
    input  logic                           m_ev_tready_i
);
    localparam int N = `EB_NUM_LINKS;

    logic                                ev_rst;
    logic [N-1:0]                        link_mask;
    logic [N-1:0][63:0]                  payload;
    logic [N-1:0]                        payload_valid;
    logic [N-1:0]                        payload_pop;
    event_pkg::hdr_word_u [N-1:0]        link_hdr;
    logic [N-1:0]                        frag_ready;
    logic [N-1:0]                        hdr_taken;
    logic                                start;
    event_pkg::hdr_word_u                event_hdr;
    logic [N-1:0]                        event_mask;
    logic                                done;

    event_ctrl_regs u_regs (
        .aclk        (aclk),
        .rst_i       (rst_i),
        .reg_wr_i    (reg_wr_i),
        .reg_addr_i  (reg_addr_i),
        .reg_wdata_i (reg_wdata_i),
        .reg_rdata_o (reg_rdata_o),
        .ev_rst_o    (ev_rst),
        .link_mask_o (link_mask)
    );

    ////////////////////
    // per-link accumulators
    ////////////////////
    for (genvar i = 0; i < N; i++) begin : g_link
        link_event_accumulator u_accum (
            .aclk            (aclk),
            .rst_i           (ev_rst),
            .link_id_i       (4'(i)),
            .enable_i        (link_mask[i]),
            .s_tdata_i       (s_link_tdata_i[i]),
            .s_tvalid_i      (s_link_tvalid_i[i]),
            .s_tlast_i       (s_link_tlast_i[i]),
            .s_tready_o      (s_link_tready_o[i]),
            .payload_o       (payload[i]),
            .payload_valid_o (payload_valid[i]),
            .payload_pop_i   (payload_pop[i]),
            .hdr_o           (link_hdr[i]),
            .frag_ready_o    (frag_ready[i]),
            .hdr_taken_i     (hdr_taken[i])
        );
    end

    event_header_merger u_merger (
        .aclk         (aclk),
        .rst_i        (ev_rst),
        .link_mask_i  (link_mask),
        .frag_ready_i (frag_ready),
        .hdr_taken_o  (hdr_taken),
        .start_o      (start),
        .event_hdr_o  (event_hdr),
        .event_mask_o (event_mask),
        .done_i       (done)
    );

    event_readout u_readout (
        .aclk            (aclk),
        .rst_i           (ev_rst),
        .start_i         (start),
        .event_hdr_i     (event_hdr),
        .event_mask_i    (event_mask),
        .link_hdr_i      (link_hdr),
        .payload_i       (payload),
        .payload_valid_i (payload_valid),
        .payload_pop_o   (payload_pop),
        .done_o          (done),
        .m_tdata_o       (m_ev_tdata_o),
        .m_tvalid_o      (m_ev_tvalid_o),
        .m_tlast_o       (m_ev_tlast_o),
        .m_tready_i      (m_ev_tready_i)
    );

    // headers are only taken from links that still hold a finished fragment
    assert property (@(posedge aclk) disable iff (ev_rst)
        (hdr_taken & ~frag_ready) == '0);

endmodule

//--- tb_event_builder.sv
`timescale 1ns/1ps
`include "event_builder_settings.svh"

module tb_event_builder;
    localparam int N           = `EB_NUM_LINKS;
    localparam int NUM_ENTRIES = 8;

    ////////////////////
    // stimulus table
    ////////////////////
    localparam logic [3:0] TBL_MASK [NUM_ENTRIES] = '{
        4'hF, 4'hF, 4'h5, 4'hA, 4'h1, 4'hF, 4'h8, 4'hF
    };
    // fragment length per link in 32-bit words, masked links included
    localparam int TBL_LEN [NUM_ENTRIES][N] = '{
        '{1, 2, 3, 4},
        '{5, 8, 7, 16},
        '{6, 9, 3, 2},
        '{4, 1, 10, 11},
        '{128, 3, 3, 3},
        '{13, 2, 1, 6},
        '{5, 5, 5, 31},
        '{64, 33, 17, 9}
    };

    logic               aclk;
    logic               rst_i;
    logic               reg_wr_i;
    logic [3:0]         reg_addr_i;
    logic [31:0]        reg_wdata_i;
    logic [31:0]        reg_rdata_o;
    logic [N-1:0][31:0] s_link_tdata_i;
    logic [N-1:0]       s_link_tvalid_i;
    logic [N-1:0]       s_link_tlast_i;
    logic [N-1:0]       s_link_tready_o;
    logic [63:0]        m_ev_tdata_o;
    logic               m_ev_tvalid_o;
    logic               m_ev_tlast_o;
    logic               m_ev_tready_i;

    logic [15:0] lfsr_q;
    logic        backpressure;
    int          events_out = 0;
    int          events_sent;
    logic [63:0] exp_word [$];
    logic        exp_is_hdr [$];
    logic        exp_last [$];
    logic [31:0] frag [N][`EB_MAX_FRAG_WORDS];
    logic [31:0] ev_num;
    logic [15:0] link_cnt [N];

    event_builder_top uut (
        .aclk            (aclk),
        .rst_i           (rst_i),
        .reg_wr_i        (reg_wr_i),
        .reg_addr_i      (reg_addr_i),
        .reg_wdata_i     (reg_wdata_i),
        .reg_rdata_o     (reg_rdata_o),
        .s_link_tdata_i  (s_link_tdata_i),
        .s_link_tvalid_i (s_link_tvalid_i),
        .s_link_tlast_i  (s_link_tlast_i),
        .s_link_tready_o (s_link_tready_o),
        .m_ev_tdata_o    (m_ev_tdata_o),
        .m_ev_tvalid_o   (m_ev_tvalid_o),
        .m_ev_tlast_o    (m_ev_tlast_o),
        .m_ev_tready_i   (m_ev_tready_i)
    );

    initial begin
        aclk = 1'b0;
        forever begin
            #20 aclk = ~aclk;
        end
    end

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic logic take_bit();
        logic fb;
        fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
        lfsr_q = {lfsr_q[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] take_word();
        logic [31:0] w;
        for (int b = 0; b < 32; b++) begin
            w[b] = take_bit();
        end
        return w;
    endfunction

    task automatic abort(input string line);
        $display("%s", line);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    ////////////////////
    // compare tasks
    ////////////////////
    task automatic check_hdr(input event_pkg::hdr_word_u got, input event_pkg::hdr_word_u exp);
        if (got !== exp) begin
            abort($sformatf("[FAIL] %0t: header word %h, expected %h", $time, got, exp));
        end
    endtask

    task automatic check_payload(input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            abort($sformatf("[FAIL] %0t: payload word %h, expected %h", $time, got, exp));
        end
    endtask

    task automatic check_reg(input ctrl_pkg::ctrl_word_t got, input ctrl_pkg::ctrl_word_t exp,
                             input string what);
        if (got !== exp) begin
            abort($sformatf("[FAIL] %0t: %s read %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort($sformatf("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    // one clock edge, output ready follows the LFSR under back-pressure
    task automatic tick();
        @(posedge aclk);
        m_ev_tready_i <= backpressure ? take_bit() : 1'b1;
    endtask

    task automatic write_reg(input ctrl_pkg::reg_addr_e addr, input logic [31:0] data);
        tick();
        reg_wr_i    <= 1'b1;
        reg_addr_i  <= addr;
        reg_wdata_i <= data;
        tick();
        reg_wr_i    <= 1'b0;
    endtask

    task automatic read_check(input ctrl_pkg::reg_addr_e addr, input ctrl_pkg::ctrl_word_t exp);
        tick();
        reg_addr_i <= addr;
        @(negedge aclk);
        check_reg(reg_rdata_o, exp, addr.name());
    endtask

    task automatic push_word(input logic [63:0] w, input logic is_hdr, input logic last);
        exp_word.push_back(w);
        exp_is_hdr.push_back(is_hdr);
        exp_last.push_back(last);
    endtask

    // reference model for one event
    task automatic build_expected(input int idx);
        event_pkg::hdr_word_u h;
        logic [3:0]           mask;
        int                   pay;
        int                   top;
        logic [31:0]          hi;
        mask = TBL_MASK[idx];
        top  = 0;
        for (int i = 0; i < N; i++) begin
            if (mask[i]) begin
                top = i;
            end
        end
        h              = '0;
        h.ev.tag       = `EB_TAG_EVENT;
        h.ev.link_mask = mask;
        h.ev.event_num = ev_num;
        push_word(h, 1'b1, 1'b0);
        for (int i = 0; i < N; i++) begin
            if (mask[i]) begin
                pay               = (TBL_LEN[idx][i] + 1) / 2;
                h                 = '0;
                h.lnk.tag         = `EB_TAG_LINK + 8'(i);
                h.lnk.link_num    = 4'(i);
                h.lnk.event_count = link_cnt[i];
                h.lnk.frag_len    = 16'(TBL_LEN[idx][i]);
                h.lnk.pay_len     = 16'(pay);
                push_word(h, 1'b1, 1'b0);
                for (int w = 0; w < pay; w++) begin
                    // odd length leaves the top half of the final word empty
                    hi = (2 * w + 1 < TBL_LEN[idx][i]) ? frag[i][2 * w + 1] : 32'h0;
                    push_word({hi, frag[i][2 * w]}, 1'b0, (i == top) && (w == pay - 1));
                end
                link_cnt[i] = link_cnt[i] + 16'd1;
            end
        end
        ev_num = ev_num + 32'd1;
    endtask

    // all four links in parallel, masked ones too
    task automatic send_fragments(input int idx);
        int   pos [N];
        logic accepted [N];
        logic busy;
        tick();
        for (int i = 0; i < N; i++) begin
            pos[i] = 0;
            s_link_tdata_i[i]  <= frag[i][0];
            s_link_tvalid_i[i] <= 1'b1;
            s_link_tlast_i[i]  <= TBL_LEN[idx][i] == 1;
        end
        busy = 1'b1;
        while (busy) begin
            @(negedge aclk);
            for (int i = 0; i < N; i++) begin
                accepted[i] = s_link_tvalid_i[i] && s_link_tready_o[i];
            end
            tick();
            busy = 1'b0;
            for (int i = 0; i < N; i++) begin
                if (accepted[i]) begin
                    pos[i]++;
                    if (pos[i] == TBL_LEN[idx][i]) begin
                        s_link_tvalid_i[i] <= 1'b0;
                        s_link_tlast_i[i]  <= 1'b0;
                    end else begin
                        s_link_tdata_i[i] <= frag[i][pos[i]];
                        s_link_tlast_i[i] <= pos[i] == TBL_LEN[idx][i] - 1;
                    end
                end
                if (pos[i] < TBL_LEN[idx][i]) begin
                    busy = 1'b1;
                end
            end
        end
    endtask

    task automatic run_entry(input int idx);
        ctrl_pkg::ctrl_word_t exp;
        exp           = '0;
        exp.link_mask = TBL_MASK[idx];
        write_reg(ctrl_pkg::REG_MASK, {20'h0, TBL_MASK[idx], 8'h0});
        read_check(ctrl_pkg::REG_MASK, exp);
        for (int i = 0; i < N; i++) begin
            for (int k = 0; k < TBL_LEN[idx][i]; k++) begin
                frag[i][k] = take_word();
            end
        end
        build_expected(idx);
        events_sent++;
        send_fragments(idx);
        while (events_out < events_sent) begin
            tick();
        end
    endtask

    task automatic soft_reset();
        ctrl_pkg::ctrl_word_t exp;
        exp             = '0;
        exp.event_reset = 1'b1;
        write_reg(ctrl_pkg::REG_CTRL, 32'h1);
        read_check(ctrl_pkg::REG_CTRL, exp);
        repeat (4) tick();
        write_reg(ctrl_pkg::REG_CTRL, 32'h0);
        read_check(ctrl_pkg::REG_CTRL, '0);
        repeat (3) tick();
        // numbering starts over after the event reset
        ev_num = '0;
        for (int i = 0; i < N; i++) begin
            link_cnt[i] = '0;
        end
    endtask

    ////////////////////
    // output monitor
    ////////////////////
    always @(negedge aclk) begin
        if (!rst_i && m_ev_tvalid_o && m_ev_tready_i) begin
            if (exp_word.size() == 0) begin
                abort($sformatf("[FAIL] %0t: unexpected output word %h", $time, m_ev_tdata_o));
            end else begin
                if (exp_is_hdr[0]) begin
                    check_hdr(m_ev_tdata_o, exp_word[0]);
                end else begin
                    check_payload(m_ev_tdata_o, exp_word[0]);
                end
                check_flag(m_ev_tlast_o, exp_last[0], "output tlast");
                if (m_ev_tlast_o) begin
                    events_out = events_out + 1;
                end
                void'(exp_word.pop_front());
                void'(exp_is_hdr.pop_front());
                void'(exp_last.pop_front());
            end
        end
    end

    // watchdog, two rounds of the table plus reset and register traffic
    initial begin
        int limit;
        int sum;
        limit = 300;
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            sum = 0;
            for (int i = 0; i < N; i++) begin
                sum += TBL_LEN[e][i];
            end
            limit += 2 * (100 + 4 * sum);
        end
        repeat (limit) @(posedge aclk);
        abort($sformatf("timeout: the run did not finish within %0d clock cycles", limit));
    end

    initial begin
        ctrl_pkg::ctrl_word_t exp;
        lfsr_q          = 16'd13281;
        backpressure    = 1'b0;
        events_sent     = 0;
        ev_num          = '0;
        rst_i           = 1'b1;
        reg_wr_i        = 1'b0;
        reg_addr_i      = '0;
        reg_wdata_i     = '0;
        s_link_tdata_i  = '0;
        s_link_tvalid_i = '0;
        s_link_tlast_i  = '0;
        m_ev_tready_i   = 1'b1;
        for (int i = 0; i < N; i++) begin
            link_cnt[i] = '0;
        end
        repeat (5) @(posedge aclk);
        rst_i <= 1'b0;
        repeat (3) tick();

        @(negedge aclk);
        check_flag(&s_link_tready_o, 1'b1, "link tready after reset");
        check_flag(m_ev_tvalid_o, 1'b0, "output tvalid after reset");
        exp           = '0;
        exp.link_mask = 4'hF;
        read_check(ctrl_pkg::REG_MASK, exp);

        // first round with a free output, second under back-pressure
        for (int round = 0; round < 2; round++) begin
            backpressure = round == 1;
            for (int e = 0; e < NUM_ENTRIES; e++) begin
                run_entry(e);
            end
            if (round == 0) begin
                soft_reset();
            end
        end

        repeat (4) tick();
        if (exp_word.size() == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            abort($sformatf("%0d expected output words never appeared", exp_word.size()));
        end
    end

endmodule

//--- event_builder.f
+incdir+.
event_pkg.sv
ctrl_pkg.sv
sync_fifo.sv
event_ctrl_regs.sv
link_event_accumulator.sv
event_header_merger.sv
event_readout.sv
event_builder_top.sv
tb_event_builder.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_event_builder
FILELIST  ?= event_builder.f
BUILD_DIR ?= obj_dir
PASS_MSG  := === PASS ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
